//--- filelist.f
source/music_pkg.sv
source/song_rom.sv
source/beat_generator.sv
source/song_reader.sv
source/note_player.sv
source/music_top.sv
test/tb_clock.sv
test/music_checker.sv
test/music_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module music_tb -f filelist.f -o music_sim; then
    echo "verilator build failed"
    exit 1
fi

# keep running past a checker error so the testbench can report it
sim_output=$(./obj_dir/music_sim +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "all tests passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- source/beat_generator.sv
`timescale 1ns/1ps

module beat_generator #(
    parameter int BEAT_CYCLES = 8
) (
    input  logic clk,
    input  logic reset,
    output logic beat
);

    localparam int CNT_W = (BEAT_CYCLES > 1) ? $clog2(BEAT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(BEAT_CYCLES - 1);

    logic [CNT_W-1:0] count;

    // free running, wraps at the end of each period.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (count == LAST)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // first cycle after reset sees count 0.
    assign beat = (count == LAST);

endmodule

//--- source/music_pkg.sv
package music_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // song geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int SONG_LENGTH = 64;        // words per song region.

    typedef logic [5:0] note_t;             // 0 is silence.
    typedef logic [5:0] duration_t;         // in beats.
    typedef logic [1:0] song_sel_t;
    typedef logic [7:0] rom_addr_t;         // {song, position}.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // song word and voice bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic       advance;                // set on an advance word.
        note_t      note;
        duration_t  duration;               // wait length on an advance word.
        logic [2:0] spare;
    } song_word_t;

    typedef struct packed {
        note_t     note;
        duration_t duration;
    } voice_t;

    // slot 0 is the first note after an advance.
    typedef voice_t [2:0] chord_t;

    typedef enum logic [1:0] {
        PAUSED,
        FETCH,
        LOAD,
        ADVANCE
    } reader_state_t;

endpackage

//--- source/music_top.sv
`timescale 1ns/1ps

module music_top #(
    parameter int BEAT_CYCLES = 8,
    parameter int TONE_SHIFT  = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 play,
    input  music_pkg::song_sel_t song,
    output music_pkg::chord_t    chord,
    output logic                 new_note,
    output logic                 song_done,
    output logic [2:0]           voice_active,
    output logic [1:0]           audio_level
);
    import music_pkg::*;

    logic       beat;
    rom_addr_t  rom_addr;
    song_word_t rom_word;
    logic [2:0] wave;

    beat_generator #(
        .BEAT_CYCLES(BEAT_CYCLES)
    ) u_beat (
        .clk   (clk),
        .reset (reset),
        .beat  (beat)
    );

    song_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .word (rom_word)
    );

    song_reader u_reader (
        .clk       (clk),
        .reset     (reset),
        .play      (play),
        .beat      (beat),
        .song      (song),
        .rom_word  (rom_word),
        .rom_addr  (rom_addr),
        .chord     (chord),
        .new_note  (new_note),
        .song_done (song_done)
    );

    for (genvar k = 0; k < 3; k++)
    begin : g_voice
        note_player #(
            .TONE_SHIFT(TONE_SHIFT)
        ) u_player (
            .clk    (clk),
            .reset  (reset),
            .beat   (beat),
            .load   (new_note),
            .voice  (chord[k]),
            .active (voice_active[k]),
            .wave   (wave[k])
        );
    end

    // three voices at most, so the sum tops out at 3.
    assign audio_level = {1'b0, wave[0]} + {1'b0, wave[1]} + {1'b0, wave[2]};

endmodule

//--- source/note_player.sv
`timescale 1ns/1ps

module note_player #(
    parameter int TONE_SHIFT = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              beat,
    input  logic              load,
    input  music_pkg::voice_t voice,
    output logic              active,
    output logic              wave
);
    import music_pkg::*;

    localparam int PHASE_W = 12;

    note_t              note;
    duration_t          remaining;
    logic [PHASE_W-1:0] phase;
    logic [PHASE_W-1:0] step;
    logic [PHASE_W:0]   phase_sum;          // carry out toggles the wave.
    logic               level;

    assign step      = PHASE_W'(note) << TONE_SHIFT;
    assign phase_sum = {1'b0, phase} + {1'b0, step};
    assign active    = (note != '0) && (remaining != '0);
    assign wave      = level & active;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tone and duration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            note      <= '0;
            remaining <= '0;
            phase     <= '0;
            level     <= 1'b0;
        end
        else if (load)
        begin
            note      <= voice.note;
            remaining <= voice.duration;
            phase     <= '0;
            level     <= 1'b0;
        end
        else
        begin
            if (beat && remaining != '0)
            begin
                remaining <= remaining - 1'b1;
            end
            if (active)
            begin
                phase <= phase_sum[PHASE_W-1:0];
                if (phase_sum[PHASE_W])
                begin
                    level <= ~level;
                end
            end
            else
            begin
                phase <= '0;                        // silent voice rests low.
                level <= 1'b0;
            end
        end
    end

endmodule

//--- source/song_data.hex
// one 16-bit word per entry, 16 words per line, 64 words per song
// word bits: advance[15] note[14:9] duration[8:3] spare[2:0]
// song 0
@00
1410 2818 8010 4208 0A20 5010 7E28 8018 8000 1835 8008 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 8008
// song 1
@40
0E18 8020 6410 3208 8010 03F8 8008 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 8008
// song 2
@80
1C10 2C18 8008 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 8008
// song 3
@C0
3020 8010 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 8008

//--- source/song_reader.sv
`timescale 1ns/1ps

module song_reader (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  play,
    input  logic                  beat,
    input  music_pkg::song_sel_t  song,
    input  music_pkg::song_word_t rom_word,
    output music_pkg::rom_addr_t  rom_addr,
    output music_pkg::chord_t     chord,
    output logic                  new_note,
    output logic                  song_done
);
    import music_pkg::*;

    localparam int POS_W = $clog2(SONG_LENGTH) + 1;

    reader_state_t    state;
    logic [POS_W-1:0] position;         // top bit set past the last word.
    logic [POS_W-1:0] position_inc;
    song_sel_t        song_q;
    chord_t           slots;
    logic [1:0]       slot_idx;
    duration_t        countdown;
    logic             held;             // chord already out, advance was cut short.

    assign position_inc = position + 1'b1;
    assign rom_addr     = {song_q, position[POS_W-2:0]};
    assign song_done    = position[POS_W-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reader FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= PAUSED;
            position  <= '0;
            song_q    <= '0;
            slots     <= '0;
            slot_idx  <= '0;
            countdown <= '0;
            held      <= 1'b0;
            chord     <= '0;
            new_note  <= 1'b0;
        end
        else
        begin
            new_note <= 1'b0;
            case (state)
                PAUSED:
                begin
                    if (!play)
                    begin
                        song_q <= song;
                        if (song != song_q)
                        begin
                            // new song restarts from its first word.
                            position <= '0;
                            slots    <= '0;
                            slot_idx <= '0;
                            held     <= 1'b0;
                        end
                    end
                    else if (!song_done)
                    begin
                        state <= FETCH;
                    end
                end

                FETCH:
                begin
                    state <= play ? LOAD : PAUSED;  // rom word lands next cycle.
                end

                LOAD:
                begin
                    if (!play)
                    begin
                        state <= PAUSED;
                    end
                    else if (rom_word.advance)
                    begin
                        if (!held)
                        begin
                            chord    <= slots;
                            new_note <= 1'b1;
                        end
                        held      <= 1'b0;
                        countdown <= rom_word.duration;
                        state     <= ADVANCE;
                    end
                    else
                    begin
                        slots[slot_idx].note     <= rom_word.note;
                        slots[slot_idx].duration <= rom_word.duration;
                        if (slot_idx != 2'd2)
                        begin
                            slot_idx <= slot_idx + 1'b1;    // extra notes land in slot 2.
                        end
                        position <= position_inc;
                        state    <= position_inc[POS_W-1] ? PAUSED : FETCH;
                    end
                end

                ADVANCE:
                begin
                    if (!play)
                    begin
                        held  <= 1'b1;                      // word is read again later.
                        state <= PAUSED;
                    end
                    else if (countdown == '0)
                    begin
                        position <= position_inc;
                        slots    <= '0;
                        slot_idx <= '0;
                        state    <= position_inc[POS_W-1] ? PAUSED : FETCH;
                    end
                    else if (beat)
                    begin
                        countdown <= countdown - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- source/song_rom.sv
`timescale 1ns/1ps

module song_rom (
    input  logic                  clk,
    input  music_pkg::rom_addr_t  addr,
    output music_pkg::song_word_t word
);
    import music_pkg::*;

    localparam int DEPTH = 4 * SONG_LENGTH;

    logic [$bits(song_word_t)-1:0] mem [0:DEPTH-1];

    initial
    begin
        $readmemh("source/song_data.hex", mem);
    end

    // one cycle from address to word.
    always_ff @(posedge clk)
    begin
        word <= song_word_t'(mem[addr]);
    end

endmodule

//--- test/music_checker.sv
`timescale 1ns/1ps

module music_checker #(
    parameter int BEAT_CYCLES = 8
) (
    input logic              clk,
    input logic              reset,
    input logic              play,
    input logic              beat,
    input logic              new_note,
    input logic              song_done,
    input music_pkg::chord_t chord,
    input logic [2:0]        voice_active,
    input logic [2:0]        wave,
    input logic [1:0]        audio_level
);

    int failures = 0;
    int gap;                    // cycles since the last beat.

    always_ff @(posedge clk)
    begin
        if (reset || beat)
        begin
            gap <= 0;
        end
        else
        begin
            gap <= gap + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // timing rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_values: assert property (@(posedge clk)
        $past(reset) && !reset |-> !new_note && !song_done && chord == '0
            && voice_active == '0 && audio_level == '0)
        else begin failures++; $error("outputs not idle after reset"); end

    a_beat_spacing: assert property (@(posedge clk) disable iff (reset)
        beat |-> gap == BEAT_CYCLES - 1)
        else begin failures++; $error("beat came early"); end

    a_beat_due: assert property (@(posedge clk) disable iff (reset)
        gap == BEAT_CYCLES - 1 |-> beat)
        else begin failures++; $error("beat missing"); end

    a_pulse_width: assert property (@(posedge clk) disable iff (reset)
        new_note |=> !new_note)
        else begin failures++; $error("new_note longer than one cycle"); end

    // paused reader keeps quiet.
    a_pause_holds: assert property (@(posedge clk) disable iff (reset)
        !play |=> !new_note && $stable(chord))
        else begin failures++; $error("chord moved while paused"); end

    a_done_quiet: assert property (@(posedge clk) disable iff (reset)
        song_done |-> !new_note)
        else begin failures++; $error("new_note after song end"); end

    a_level_sum: assert property (@(posedge clk) disable iff (reset)
        int'(audio_level) == $countones(wave & voice_active))
        else begin failures++; $error("audio_level differs from active wave count"); end

    a_silent: assert property (@(posedge clk) disable iff (reset)
        voice_active == '0 |-> audio_level == '0 && (wave & ~voice_active) == '0)
        else begin failures++; $error("sound from an inactive voice"); end

endmodule

//--- test/music_tb.sv
`timescale 1ns/1ps

module music_tb;
    import music_pkg::*;

    localparam int BEAT_CYCLES = 8;
    localparam int TONE_SHIFT  = 2;
    localparam int TIMEOUT     = 4 * SONG_LENGTH * (2 + 63 * BEAT_CYCLES) + 1000;

    logic       clk;
    logic       reset;
    logic       play;
    song_sel_t  song;
    chord_t     chord;
    logic       new_note;
    logic       song_done;
    logic [2:0] voice_active;
    logic [1:0] audio_level;

    logic [15:0] model_mem [0:4*SONG_LENGTH-1];
    chord_t      expected[$];
    duration_t   waits[$];
    duration_t   last_wait;
    logic        have_prev = 1'b0;
    int          beats_seen = 0;
    int          cycle = 0;
    note_t       voice_note [3];
    duration_t   voice_left [3];

    tb_clock clock0 (.clk(clk));

    music_top #(
        .BEAT_CYCLES(BEAT_CYCLES),
        .TONE_SHIFT (TONE_SHIFT)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .play         (play),
        .song         (song),
        .chord        (chord),
        .new_note     (new_note),
        .song_done    (song_done),
        .voice_active (voice_active),
        .audio_level  (audio_level)
    );

    bind music_top music_checker #(
        .BEAT_CYCLES(BEAT_CYCLES)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .play         (play),
        .beat         (beat),
        .new_note     (new_note),
        .song_done    (song_done),
        .chord        (chord),
        .voice_active (voice_active),
        .wave         (wave),
        .audio_level  (audio_level)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // chords one song publishes, in order, with their waits.
    task automatic build_expected(input song_sel_t which);
        chord_t     slots;
        int         idx;
        song_word_t w;
        slots = '0;
        idx   = 0;
        for (int p = 0; p < SONG_LENGTH; p++)
        begin
            w = song_word_t'(model_mem[{which, 6'(p)}]);
            if (w.advance)
            begin
                expected.push_back(slots);
                waits.push_back(w.duration);
                slots = '0;
                idx   = 0;
            end
            else
            begin
                slots[idx].note     = w.note;
                slots[idx].duration = w.duration;
                if (idx < 2)
                begin
                    idx++;              // a fourth note lands in slot 2 again.
                end
            end
        end
    endtask

    task automatic play_song(input song_sel_t which);
        build_expected(which);
        play = 1'b1;
        while (!song_done)
        begin
            @(posedge clk);
            #1;
            if (play)
            begin
                if ($urandom % 40 == 0)
                begin
                    play = 1'b0;
                end
            end
            else if ($urandom % 6 == 0)
            begin
                play = 1'b1;
            end
        end
        play = 1'b1;
        repeat (4 * BEAT_CYCLES) @(posedge clk);   // play stays high past the end.
        #1;
        assert (expected.size() == 0)
        else report_failure($sformatf("song %0d ended with %0d chords due", which,
                                      expected.size()));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk)
    begin : monitor
        logic want;
        cycle++;
        if (cycle > TIMEOUT)
        begin
            report_failure($sformatf("run timed out after %0d cycles", cycle));
        end
        if (dut0.u_checker.failures != 0)
        begin
            report_failure("a timing assertion failed");
        end
        if (reset)
        begin
            for (int k = 0; k < 3; k++)
            begin
                voice_note[k] = '0;
                voice_left[k] = '0;
            end
        end
        else
        begin
            for (int k = 0; k < 3; k++)
            begin
                want = (voice_note[k] != '0) && (voice_left[k] != '0);
                assert (voice_active[k] == want)
                else report_failure($sformatf("ERR voice_active[%0d] expected %h actual %h",
                                              k, want, voice_active[k]));
                if (new_note)
                begin
                    voice_note[k] = chord[k].note;
                    voice_left[k] = chord[k].duration;
                end
                else if (dut0.beat && voice_left[k] != '0)
                begin
                    voice_left[k]--;
                end
            end
            if (new_note)
            begin
                assert (!have_prev || beats_seen >= int'(last_wait))
                else report_failure("new_note came before the advance wait ended");
                assert (expected.size() != 0)
                else report_failure("new_note with no chord left in the song");
                assert (chord == expected[0])
                else report_failure($sformatf("ERR chord expected %h actual %h",
                                              expected[0], chord));
                void'(expected.pop_front());
                last_wait  = waits.pop_front();
                have_prev  = 1'b1;
                beats_seen = 0;
            end
            if (dut0.beat)
            begin
                beats_seen++;
            end
        end
    end

    initial
    begin
        void'($urandom(39));
        $readmemh("source/song_data.hex", model_mem);
        reset = 1'b1;
        play  = 1'b0;
        song  = 2'd0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        play_song(2'd0);

        play = 1'b0;
        song = 2'd1;                            // switch while paused.
        repeat (2) @(posedge clk);
        #1;
        assert (!song_done)
        else report_failure("song_done still high after the song changed");

        play_song(2'd1);

        if (dut0.u_checker.failures != 0)
        begin
            report_failure("a timing assertion failed");
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk = ~clk;   // first rising edge at half a period.
        end
    end

endmodule
